/* tcdm_split_pkg.sv */
/*
 * tcdm split package
 * widths, depths, register map and channel payload types shared by the split stage
 */
`default_nettype none

package tcdm_split_pkg;

  localparam int unsigned NB_CHAN = 2;  // output channels
  localparam int unsigned DW      = 64; // wide data
  localparam int unsigned DW_CHAN = 32; // per-channel data
  localparam int unsigned BW_CHAN = 4;  // per-channel byte enables
  localparam int unsigned AW      = 32;

  localparam int unsigned CHAN_FIFO_DEPTH = 2;

  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned BANK_AW    = 6; // word index width

  localparam int unsigned STALL_W = 8; // stall pattern length in cycles

  // config register map
  localparam int unsigned CFG_AW = 4;
  localparam logic [CFG_AW-1:0] CFG_STALL0 = 4'd0;
  localparam logic [CFG_AW-1:0] CFG_STALL1 = 4'd4;
  localparam logic [CFG_AW-1:0] CFG_CLEAR  = 4'd8; // write-only strobe

  typedef struct packed {
    logic [AW-1:0]      add;
    logic               wen;  // 1 = read
    logic [BW_CHAN-1:0] be;
    logic [DW_CHAN-1:0] data;
  } chan_req_t;

  typedef struct packed {
    logic [DW_CHAN-1:0] r_data;
  } chan_rsp_t;

endpackage

`default_nettype wire

/* tcdm_chan_fifo.sv */
/*
 * channel FIFO
 * small circular buffer with push/full and pop/empty, generic payload type
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_chan_fifo #(
  parameter type payload_t = tcdm_split_pkg::chan_rsp_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output logic     empty_o,
  output payload_t data_o
);

  logic [$clog2(tcdm_split_pkg::CHAN_FIFO_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(tcdm_split_pkg::CHAN_FIFO_DEPTH+1)-1:0] cnt_q; // fill level
  payload_t mem_q [tcdm_split_pkg::CHAN_FIFO_DEPTH];
  logic     do_push, do_pop;

  assign full_o  = (cnt_q == tcdm_split_pkg::CHAN_FIFO_DEPTH);
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o; // push while full is dropped, caller sees full_o
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];  // head is valid whenever empty_o is low

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == tcdm_split_pkg::CHAN_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == tcdm_split_pkg::CHAN_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q; // both or neither, level unchanged
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* tcdm_split.sv */
/*
 * tcdm split
 * splits one 64-bit request into two 32-bit channel requests through FIFOs,
 * masks already granted channels and joins channel read responses in order
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_split (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  // wide port
  input  logic                                               req_i,
  input  logic [tcdm_split_pkg::AW-1:0]                      add_i,
  input  logic                                               wen_i,
  input  logic [tcdm_split_pkg::NB_CHAN*tcdm_split_pkg::BW_CHAN-1:0] be_i,
  input  logic [tcdm_split_pkg::DW-1:0]                      data_i,
  input  logic                                               r_ready_i,
  output logic                                               gnt_o,
  output logic                                               r_valid_o,
  output logic [tcdm_split_pkg::DW-1:0]                      r_data_o,
  // channel ports
  input  logic [tcdm_split_pkg::NB_CHAN-1:0]                 chan_gnt_i,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0]                 chan_rvalid_i,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_CHAN-1:0] chan_rdata_i,
  output logic [tcdm_split_pkg::NB_CHAN-1:0]                 chan_req_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0] chan_add_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0]                 chan_wen_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BW_CHAN-1:0] chan_be_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_CHAN-1:0] chan_wdata_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0]                 chan_rready_o
);

  typedef enum logic {GNT, NO_GNT} gnt_state_e;
  typedef enum logic {RVALID, NO_RVALID} rsp_state_e;

  gnt_state_e gnt_cs, gnt_ns;
  rsp_state_e rsp_cs, rsp_ns;

  logic [tcdm_split_pkg::NB_CHAN-1:0] gnt_mask_q, gnt_mask_d, gnt_mask;
  logic [tcdm_split_pkg::NB_CHAN-1:0] req_push, req_full, req_empty, chan_acc;
  logic [tcdm_split_pkg::NB_CHAN-1:0] dlv_q, dlv_d, dlv_mask;
  logic [tcdm_split_pkg::NB_CHAN-1:0] rd_idle, rsp_full, rsp_empty, rsp_avail;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_CHAN-1:0] rsp_data;
  logic rsp_pop;

  for (genvar ii = 0; ii < tcdm_split_pkg::NB_CHAN; ii++) begin : gen_chan
    tcdm_split_pkg::chan_req_t req_in, req_out;
    tcdm_split_pkg::chan_rsp_t rsp_in, rsp_out;
    // reads in flight on this channel, at most req FIFO + bank + rsp FIFO
    logic [$clog2(2*tcdm_split_pkg::CHAN_FIFO_DEPTH+2)-1:0] rd_cnt_q;

    assign req_in.add  = add_i + (ii * tcdm_split_pkg::BW_CHAN); // word offset of this half
    assign req_in.wen  = wen_i;
    assign req_in.be   = be_i[ii*tcdm_split_pkg::BW_CHAN +: tcdm_split_pkg::BW_CHAN];
    assign req_in.data = data_i[ii*tcdm_split_pkg::DW_CHAN +: tcdm_split_pkg::DW_CHAN];

    assign req_push[ii] = req_i & ~gnt_mask[ii]; // already enqueued halves stay out
    assign chan_acc[ii] = req_push[ii] & ~req_full[ii];

    tcdm_chan_fifo #(
      .payload_t (tcdm_split_pkg::chan_req_t)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .clear_i (clear_i),
      .push_i  (req_push[ii]),
      .data_i  (req_in),
      .full_o  (req_full[ii]),
      .pop_i   (chan_gnt_i[ii]),
      .empty_o (req_empty[ii]),
      .data_o  (req_out)
    );

    assign chan_req_o[ii]   = ~req_empty[ii];
    assign chan_add_o[ii]   = req_out.add;
    assign chan_wen_o[ii]   = req_out.wen;
    assign chan_be_o[ii]    = req_out.be;
    assign chan_wdata_o[ii] = req_out.data;

    assign rsp_in.r_data = chan_rdata_i[ii];

    tcdm_chan_fifo #(
      .payload_t (tcdm_split_pkg::chan_rsp_t)
    ) u_rsp_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .clear_i (clear_i),
      .push_i  (chan_rvalid_i[ii]),
      .data_i  (rsp_in),
      .full_o  (rsp_full[ii]),
      .pop_i   (rsp_pop),         // all heads leave together
      .empty_o (rsp_empty[ii]),
      .data_o  (rsp_out)
    );

    assign chan_rready_o[ii] = ~rsp_full[ii]; // bank holds its response while low
    assign rsp_avail[ii]     = ~rsp_empty[ii];
    assign rsp_data[ii]      = rsp_out.r_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_cnt_q <= '0;
      end else if (clear_i) begin
        rd_cnt_q <= '0;
      end else begin
        case ({chan_acc[ii] & wen_i, rsp_pop & rsp_avail[ii]})
          2'b10:   rd_cnt_q <= rd_cnt_q + 1'b1;
          2'b01:   rd_cnt_q <= rd_cnt_q - 1'b1;
          default: rd_cnt_q <= rd_cnt_q;
        endcase
      end
    end

    // nothing in flight and no wide read still waiting to be enqueued here
    assign rd_idle[ii] = (rd_cnt_q == '0) & ~(req_i & wen_i);
  end

  // grant side
  assign gnt_mask = (gnt_cs == NO_GNT) ? gnt_mask_q : '0;
  assign gnt_o    = req_i & (&(chan_acc | gnt_mask)); // last missing half closes the request

  always_comb begin
    gnt_ns     = gnt_cs;
    gnt_mask_d = gnt_mask_q;
    if (req_i) begin
      if (gnt_o) begin
        gnt_ns     = GNT;
        gnt_mask_d = '0;
      end else begin
        gnt_ns     = NO_GNT;               // partial grant, remember who took it
        gnt_mask_d = gnt_mask | chan_acc;
      end
    end
  end

  // response side
  assign dlv_mask  = (rsp_cs == NO_RVALID) ? dlv_q : '0;
  assign r_valid_o = (|rsp_avail) & (&(rsp_avail | dlv_mask | rd_idle));
  assign r_data_o  = rsp_data; // channel 0 in the low half
  assign rsp_pop   = r_valid_o & r_ready_i;

  always_comb begin
    rsp_ns = rsp_cs;
    dlv_d  = dlv_q;
    if (rsp_pop) begin
      rsp_ns = RVALID;
      dlv_d  = '0;
    end else if ((|rsp_avail) & ~(&rsp_avail)) begin
      rsp_ns = NO_RVALID;              // some halves in, wait for the rest
      dlv_d  = dlv_mask | rsp_avail;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_cs     <= GNT;
      gnt_mask_q <= '0;
      rsp_cs     <= RVALID;
      dlv_q      <= '0;
    end else if (clear_i) begin
      gnt_cs     <= GNT;
      gnt_mask_q <= '0;
      rsp_cs     <= RVALID;
      dlv_q      <= '0;
    end else begin
      gnt_cs     <= gnt_ns;
      gnt_mask_q <= gnt_mask_d;
      rsp_cs     <= rsp_ns;
      dlv_q      <= dlv_d;
    end
  end

endmodule

`default_nettype wire

/* tcdm_bank.sv */
/*
 * tcdm bank model
 * 32-bit single-port SRAM with byte enables, pattern-driven grant stalls
 * and a one-entry read response register
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic                                  req_i,
  input  logic [tcdm_split_pkg::AW-1:0]         add_i,
  input  logic                                  wen_i,   // 1 = read
  input  logic [tcdm_split_pkg::BW_CHAN-1:0]    be_i,
  input  logic [tcdm_split_pkg::DW_CHAN-1:0]    wdata_i,
  input  logic                                  rready_i,
  input  logic [tcdm_split_pkg::STALL_W-1:0]    stall_pattern_i,
  output logic                                  gnt_o,
  output logic                                  rvalid_o,
  output logic [tcdm_split_pkg::DW_CHAN-1:0]    rdata_o
);

  logic [tcdm_split_pkg::DW_CHAN-1:0] mem_q [tcdm_split_pkg::BANK_WORDS];
  logic [$clog2(tcdm_split_pkg::STALL_W)-1:0] stall_ptr_q; // free-running pattern index
  logic [tcdm_split_pkg::BANK_AW-1:0] idx;
  logic rvalid_q, rsp_free, rd_gnt;

  assign idx      = add_i[tcdm_split_pkg::BANK_AW+2:3]; // bit 2 picks the channel, not the word
  assign rsp_free = ~rvalid_q | rready_i;
  assign gnt_o    = req_i & stall_pattern_i[stall_ptr_q] & rsp_free;
  assign rd_gnt   = gnt_o & wen_i;
  assign rvalid_o = rvalid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_ptr_q <= '0;
      rvalid_q    <= 1'b0;
    end else if (clear_i) begin
      stall_ptr_q <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      stall_ptr_q <= stall_ptr_q + 1'b1; // wraps at STALL_W
      if (rd_gnt) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;               // drained
      end
    end
  end

  // array and read data
  always_ff @(posedge clk_i) begin
    if (gnt_o && !wen_i) begin
      for (int b = 0; b < tcdm_split_pkg::BW_CHAN; b++) begin
        if (be_i[b]) mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
    if (rd_gnt) begin
      rdata_o <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

/* tcdm_split_cfg.sv */
/*
 * split stage config registers
 * per-bank stall patterns plus a self-clearing clear strobe, combinational readback
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_split_cfg (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cfg_we_i,
  input  logic [tcdm_split_pkg::CFG_AW-1:0]   cfg_addr_i,
  input  logic [31:0]                         cfg_wdata_i,
  output logic [31:0]                         cfg_rdata_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::STALL_W-1:0] stall_pattern_o,
  output logic                                clear_o
);

  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::STALL_W-1:0] stall_q;
  logic clear_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q <= '1;   // all ones, banks never stall
      clear_q <= 1'b0;
    end else begin
      clear_q <= cfg_we_i & (cfg_addr_i == tcdm_split_pkg::CFG_CLEAR); // one-cycle pulse
      if (cfg_we_i) begin
        case (cfg_addr_i)
          tcdm_split_pkg::CFG_STALL0: stall_q[0] <= cfg_wdata_i[tcdm_split_pkg::STALL_W-1:0];
          tcdm_split_pkg::CFG_STALL1: stall_q[1] <= cfg_wdata_i[tcdm_split_pkg::STALL_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    cfg_rdata_o = '0; // clear strobe and unmapped offsets read as zero
    case (cfg_addr_i)
      tcdm_split_pkg::CFG_STALL0: cfg_rdata_o[tcdm_split_pkg::STALL_W-1:0] = stall_q[0];
      tcdm_split_pkg::CFG_STALL1: cfg_rdata_o[tcdm_split_pkg::STALL_W-1:0] = stall_q[1];
      default: ;
    endcase
  end

  assign stall_pattern_o = stall_q;
  assign clear_o         = clear_q;

endmodule

`default_nettype wire

/* tcdm_split_top.sv */
/*
 * tcdm split subsystem top
 * wide port into the splitter, one SRAM bank per channel, config block alongside
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_split_top (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // wide port
  input  logic                                                       req_i,
  input  logic [tcdm_split_pkg::AW-1:0]                              add_i,
  input  logic                                                       wen_i,
  input  logic [tcdm_split_pkg::NB_CHAN*tcdm_split_pkg::BW_CHAN-1:0] be_i,
  input  logic [tcdm_split_pkg::DW-1:0]                              data_i,
  input  logic                                                       r_ready_i,
  output logic                                                       gnt_o,
  output logic                                                       r_valid_o,
  output logic [tcdm_split_pkg::DW-1:0]                              r_data_o,
  // config port
  input  logic                                                       cfg_we_i,
  input  logic [tcdm_split_pkg::CFG_AW-1:0]                          cfg_addr_i,
  input  logic [31:0]                                                cfg_wdata_i,
  output logic [31:0]                                                cfg_rdata_o
);

  logic [tcdm_split_pkg::NB_CHAN-1:0] chan_req, chan_wen, chan_gnt, chan_rvalid, chan_rready;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0]      chan_add;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BW_CHAN-1:0] chan_be;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_CHAN-1:0] chan_wdata, chan_rdata;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::STALL_W-1:0] stall_pattern;
  logic clear;

  tcdm_split_cfg u_cfg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_rdata_o     (cfg_rdata_o),
    .stall_pattern_o (stall_pattern),
    .clear_o         (clear)
  );

  tcdm_split u_split (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .req_i         (req_i),
    .add_i         (add_i),
    .wen_i         (wen_i),
    .be_i          (be_i),
    .data_i        (data_i),
    .r_ready_i     (r_ready_i),
    .gnt_o         (gnt_o),
    .r_valid_o     (r_valid_o),
    .r_data_o      (r_data_o),
    .chan_gnt_i    (chan_gnt),
    .chan_rvalid_i (chan_rvalid),
    .chan_rdata_i  (chan_rdata),
    .chan_req_o    (chan_req),
    .chan_add_o    (chan_add),
    .chan_wen_o    (chan_wen),
    .chan_be_o     (chan_be),
    .chan_wdata_o  (chan_wdata),
    .chan_rready_o (chan_rready)
  );

  // one bank per channel
  for (genvar ii = 0; ii < tcdm_split_pkg::NB_CHAN; ii++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .clear_i         (clear),
      .req_i           (chan_req[ii]),
      .add_i           (chan_add[ii]),
      .wen_i           (chan_wen[ii]),
      .be_i            (chan_be[ii]),
      .wdata_i         (chan_wdata[ii]),
      .rready_i        (chan_rready[ii]),
      .stall_pattern_i (stall_pattern[ii]),
      .gnt_o           (chan_gnt[ii]),
      .rvalid_o        (chan_rvalid[ii]),
      .rdata_o         (chan_rdata[ii])
    );
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
 * testbench clock and reset
 * 100 ns clock, active-low reset held for 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time PERIOD = 100ns;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o); // three rising edges in reset
    @(negedge clk_o);
    rst_no = 1'b1;                // released away from the sampling edge
  end

endmodule

`default_nettype wire

/* tcdm_split_properties.sv */
/*
 * tcdm split properties
 * wide and channel handshake rules plus state machine behavior under clear
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_split_properties (
  input logic                                                          clk_i,
  input logic                                                          rst_ni,
  input logic                                                          clear_i,
  input logic                                                          req_i,
  input logic                                                          gnt_i,
  input logic                                                          r_ready_i,
  input logic                                                          r_valid_i,
  input logic [tcdm_split_pkg::DW-1:0]                                 r_data_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0]                            chan_req_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0]                            chan_gnt_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0]      chan_add_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0]                            chan_wen_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BW_CHAN-1:0] chan_be_i,
  input logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_CHAN-1:0] chan_wdata_i,
  input logic                                                          gnt_state_i,
  input logic                                                          rsp_state_i
);

  int unsigned fail_cnt = 0; // failed assertions, summed into the final verdict

  // wide grant only answers a request
  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_i)
    else begin
      $error("gnt_o high without req_i");
      fail_cnt++;
    end

  // response and its data held under back-pressure
  a_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i))
    else begin
      $error("wide response changed while r_ready_i was low");
      fail_cnt++;
    end

  // GNT and RVALID both encode as 0
  a_clear_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (gnt_state_i == 1'b0) && (rsp_state_i == 1'b0))
    else begin
      $error("state machine left its reset state under clear");
      fail_cnt++;
    end

  for (genvar ii = 0; ii < tcdm_split_pkg::NB_CHAN; ii++) begin : gen_chan
    a_chan_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      chan_req_i[ii] && !chan_gnt_i[ii] |=> chan_req_i[ii] && $stable(chan_add_i[ii])
        && $stable(chan_wen_i[ii]) && $stable(chan_be_i[ii]) && $stable(chan_wdata_i[ii]))
      else begin
        $error("channel request dropped or changed before its grant");
        fail_cnt++;
      end
  end

endmodule

`default_nettype wire

/* tcdm_split_tb.sv */
/*
 * tcdm split testbench
 * directed tests on the wide port, checked against a byte-level reference memory
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_split_tb;

  localparam int unsigned MAX_CYCLES = 4000; // roughly twice the summed test length
  localparam int unsigned MEM_BYTES  = tcdm_split_pkg::BANK_WORDS * 8; // both banks together
  localparam int unsigned BE_W       = tcdm_split_pkg::NB_CHAN * tcdm_split_pkg::BW_CHAN;

  logic clk, rst_n;
  logic req, wen, r_ready, gnt, r_valid, cfg_we;
  logic [tcdm_split_pkg::AW-1:0]     add;
  logic [BE_W-1:0]                   be;
  logic [tcdm_split_pkg::DW-1:0]     wdata, r_data, hold_data;
  logic [tcdm_split_pkg::CFG_AW-1:0] cfg_addr;
  logic [31:0]                       cfg_wdata, cfg_rdata;

  logic [7:0]                    ref_mem [MEM_BYTES]; // byte address = wide address mod size
  logic [tcdm_split_pkg::DW-1:0] exp_q [$];           // expected read data, request order
  logic [tcdm_split_pkg::AW-1:0] used_adds [$];       // words fully written so far
  logic [31:0]                   lfsr_q;
  logic                          hold_pend;
  int unsigned cycles, checks, errors, tests_ok, grant_wait, prop_fails;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_split_top tcdm_split_top_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .add_i       (add),
    .wen_i       (wen),
    .be_i        (be),
    .data_i      (wdata),
    .r_ready_i   (r_ready),
    .gnt_o       (gnt),
    .r_valid_o   (r_valid),
    .r_data_o    (r_data),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  bind tcdm_split tcdm_split_properties u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .req_i        (req_i),
    .gnt_i        (gnt_o),
    .r_ready_i    (r_ready_i),
    .r_valid_i    (r_valid_o),
    .r_data_i     (r_data_o),
    .chan_req_i   (chan_req_o),
    .chan_gnt_i   (chan_gnt_i),
    .chan_add_i   (chan_add_o),
    .chan_wen_i   (chan_wen_o),
    .chan_be_i    (chan_be_o),
    .chan_wdata_i (chan_wdata_o),
    .gnt_state_i  (gnt_cs),
    .rsp_state_i  (rsp_cs)
  );

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  // random 8-byte aligned wide address inside the banks
  function automatic logic [tcdm_split_pkg::AW-1:0] pick_word();
    logic [tcdm_split_pkg::AW-1:0] a;
    logic [63:0] r;
    r = rand_bits(tcdm_split_pkg::BANK_AW);
    a = '0;
    a[tcdm_split_pkg::BANK_AW+2:3] = r[tcdm_split_pkg::BANK_AW-1:0];
    return a;
  endfunction

  // byte b of the wide word lives at address + b
  function automatic logic [tcdm_split_pkg::DW-1:0] expected_word(
      input logic [tcdm_split_pkg::AW-1:0] a);
    logic [tcdm_split_pkg::DW-1:0] v;
    for (int b = 0; b < BE_W; b++) begin
      v[b*8 +: 8] = ref_mem[(a + b) % MEM_BYTES];
    end
    return v;
  endfunction

  task automatic apply_write(input logic [tcdm_split_pkg::AW-1:0] a, input logic [BE_W-1:0] m,
                             input logic [tcdm_split_pkg::DW-1:0] d);
    for (int b = 0; b < BE_W; b++) begin
      if (m[b]) ref_mem[(a + b) % MEM_BYTES] = d[b*8 +: 8];
    end
  endtask

  task automatic check_rdata(input logic [tcdm_split_pkg::DW-1:0] got,
                             input logic [tcdm_split_pkg::DW-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cfg(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_fail(input string msg);
    errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  // hold the request until granted, the model follows in grant order
  task automatic issue_req(input logic [tcdm_split_pkg::AW-1:0] a, input logic rd,
                           input logic [BE_W-1:0] m, input logic [tcdm_split_pkg::DW-1:0] d);
    @(negedge clk);
    req   = 1'b1;
    add   = a;
    wen   = rd;  // high = read
    be    = m;
    wdata = d;
    grant_wait = 0;
    @(posedge clk);
    while (!gnt) begin
      grant_wait++;
      @(posedge clk);
    end
    if (rd) exp_q.push_back(expected_word(a));
    else apply_write(a, m, d);
  endtask

  task automatic go_idle();
    @(negedge clk);
    req = 1'b0;
  endtask

  task automatic wait_drain();
    go_idle();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic write_reg(input logic [tcdm_split_pkg::CFG_AW-1:0] a, input logic [31:0] d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we = 1'b0;   // single-cycle strobe
  endtask

  task automatic readback_reg(input logic [tcdm_split_pkg::CFG_AW-1:0] a,
                              input logic [31:0] exp, input string what);
    @(negedge clk);
    cfg_addr = a;
    @(posedge clk);
    check_cfg(cfg_rdata, exp, what);
  endtask

  task automatic finish_test(input string name, input int unsigned e0);
    if (errors == e0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // every wide response, plus hold behavior while r_ready is low
  always @(posedge clk) begin : rsp_monitor
    logic [tcdm_split_pkg::DW-1:0] exp_word;
    if (rst_n === 1'b1) begin
      if (hold_pend) begin
        if (r_valid !== 1'b1) note_fail("r_valid_o dropped while r_ready_i was low");
        else check_rdata(r_data, hold_data, "held response");
      end
      if (r_valid && r_ready) begin
        if (exp_q.size() == 0) begin
          note_fail("response arrived with no read outstanding");
        end else begin
          exp_word = exp_q.pop_front();
          check_rdata(r_data, exp_word, "read data");
        end
      end
      hold_pend = r_valid && !r_ready;
      hold_data = r_data;
    end
  end

  task automatic reset_values();
    int unsigned e0;
    e0 = errors;
    @(posedge clk);
    while (!rst_n) begin
      if (gnt || r_valid) note_fail("gnt_o or r_valid_o high during reset");
      @(posedge clk);
    end
    repeat (2) begin
      @(posedge clk);
      if (gnt || r_valid) note_fail("gnt_o or r_valid_o high after reset");
    end
    readback_reg(tcdm_split_pkg::CFG_STALL0, (1 << tcdm_split_pkg::STALL_W) - 1, "stall0 reset");
    readback_reg(tcdm_split_pkg::CFG_STALL1, (1 << tcdm_split_pkg::STALL_W) - 1, "stall1 reset");
    finish_test("reset values", e0);
  endtask

  task automatic plain_rw();
    int unsigned e0, slow;
    logic [tcdm_split_pkg::AW-1:0] a;
    e0   = errors;
    slow = 0;
    for (int i = 0; i < 16; i++) begin
      a = pick_word();
      used_adds.push_back(a);
      issue_req(a, 1'b0, '1, rand_bits(64));
      if (grant_wait != 0) slow++;
    end
    foreach (used_adds[i]) begin
      issue_req(used_adds[i], 1'b1, '0, '0);
      if (grant_wait != 0) slow++;
    end
    wait_drain();
    if (slow != 0) note_fail($sformatf("%0d requests not granted in their first cycle", slow));
    finish_test("plain write and read", e0);
  endtask

  task automatic partial_writes();
    int unsigned e0;
    e0 = errors;
    foreach (used_adds[i]) begin
      issue_req(used_adds[i], 1'b0, rand_bits(BE_W), rand_bits(64));
    end
    foreach (used_adds[i]) begin
      issue_req(used_adds[i], 1'b1, '0, '0);
    end
    wait_drain();
    finish_test("partial writes", e0);
  endtask

  task automatic stalled_banks();
    int unsigned e0, waits;
    logic [tcdm_split_pkg::AW-1:0] a;
    e0    = errors;
    waits = 0;
    write_reg(tcdm_split_pkg::CFG_STALL0, 32'h0000_006d); // 0110_1101
    write_reg(tcdm_split_pkg::CFG_STALL1, 32'h0000_0093); // 1001_0011, out of step with bank 0
    for (int i = 0; i < 12; i++) begin
      a = pick_word();
      issue_req(a, 1'b0, '1, rand_bits(64));
      waits += grant_wait;
      issue_req(a, 1'b1, '0, '0);   // read right behind the write
      waits += grant_wait;
    end
    foreach (used_adds[i]) begin
      issue_req(used_adds[i], 1'b1, '0, '0);
      waits += grant_wait;
    end
    wait_drain();
    if (waits == 0) note_fail("stall patterns never delayed a grant");
    write_reg(tcdm_split_pkg::CFG_STALL0, 32'h0000_00ff);
    write_reg(tcdm_split_pkg::CFG_STALL1, 32'h0000_00ff);
    finish_test("stalled banks", e0);
  endtask

  task automatic backpressure();
    int unsigned e0, stalled;
    e0      = errors;
    stalled = 0;
    @(negedge clk);
    r_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin  // more reads than the channels can hold
          issue_req(used_adds[i], 1'b1, '0, '0);
        end
        go_idle();
      end
      begin
        repeat (20) begin
          @(posedge clk);
          if (req && !gnt) stalled++;
        end
        @(negedge clk);
        r_ready = 1'b1;
      end
    join
    wait_drain();
    if (stalled == 0) note_fail("gnt_o never dropped while r_ready_i was low");
    finish_test("back-pressure", e0);
  endtask

  task automatic clear_strobe();
    int unsigned e0;
    e0 = errors;
    write_reg(tcdm_split_pkg::CFG_STALL0, 32'h0000_00c3);
    write_reg(tcdm_split_pkg::CFG_STALL1, 32'h0000_005a);
    write_reg(tcdm_split_pkg::CFG_CLEAR, 32'h0000_0001);
    repeat (2) begin
      @(posedge clk);
      if (gnt || r_valid) note_fail("wide port active after clear while idle");
    end
    readback_reg(tcdm_split_pkg::CFG_STALL0, 32'h0000_00c3, "stall0 readback");
    readback_reg(tcdm_split_pkg::CFG_STALL1, 32'h0000_005a, "stall1 readback");
    readback_reg(tcdm_split_pkg::CFG_CLEAR, 32'h0, "clear readback");
    readback_reg(4'hc, 32'h0, "unmapped readback");
    issue_req(used_adds[0], 1'b0, '1, rand_bits(64));
    issue_req(used_adds[0], 1'b1, '0, '0);
    wait_drain();
    finish_test("clear strobe", e0);
  endtask

  // run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, the tests did not complete", cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    req       = 1'b0;
    add       = '0;
    wen       = 1'b0;
    be        = '0;
    wdata     = '0;
    r_ready   = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    hold_pend = 1'b0;
    lfsr_q    = 32'h3ff9a4d1;
    checks    = 0;
    errors    = 0;
    tests_ok  = 0;
    reset_values();
    plain_rw();
    partial_writes();
    stalled_banks();
    backpressure();
    clear_strobe();
    repeat (4) @(posedge clk);  // let late responses show up
    prop_fails = tcdm_split_top_inst.u_split.u_props.fail_cnt;
    $display("tests passed %0d of 6, checks %0d, errors %0d, assertion failures %0d",
             tests_ok, checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
tcdm_split_pkg.sv
tcdm_chan_fifo.sv
tcdm_split.sv
tcdm_bank.sv
tcdm_split_cfg.sv
tcdm_split_top.sv
tb_clock_gen.sv
tcdm_split_properties.sv
tcdm_split_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the split stage testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tcdm_split_tb \
  -f filelist.f -o tcdm_split_sim || { echo "build failed"; exit 1; }

# keep running past assertion errors so the testbench can print its verdict
out=$(./obj_dir/tcdm_split_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
